//--- project.f
+incdir+source
source/pe_pkg.sv
source/pe_bus_decoder.sv
source/pe_rtc.sv
source/pe_plic.sv
source/pe_dma_mux.sv
source/pe_periph_top.sv
verification/pe_assertions.sv
verification/pe_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and search the output for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pe_tb -f project.f -o pe_sim \
    && ./obj_dir/pe_sim | tee /dev/stderr | grep "Regression passed" > /dev/null \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

//--- source/pe_bus_decoder.sv
`timescale 1ns/1ps

`include "pe_defs.svh"

module pe_bus_decoder
    import pe_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  bus_en_i,
    input  logic [`PE_ADDR_W-1:0] bus_addr_i,

    output logic                  dmem_en_o,
    output logic                  rtc_en_o,
    output logic                  plic_en_o,

    input  logic [`PE_DATA_W-1:0] rtc_rdata_i,
    input  logic [`PE_DATA_W-1:0] plic_rdata_i,
    input  logic [`PE_DATA_W-1:0] dmem_rdata_i,
    output logic [`PE_DATA_W-1:0] bus_rdata_o
);

    region_e region;
    region_e region_q;

    // Region from the upper address byte
    always_comb begin
        case (bus_addr_i[`PE_ADDR_W-1 -: 8])
            `PE_REGION_DMEM: region = REGION_DMEM;
            `PE_REGION_RTC:  region = REGION_RTC;
            `PE_REGION_PLIC: region = REGION_PLIC;
            default:         region = REGION_NONE;
        endcase
    end

    assign dmem_en_o = bus_en_i && (region == REGION_DMEM);
    assign rtc_en_o  = bus_en_i && (region == REGION_RTC);
    assign plic_en_o = bus_en_i && (region == REGION_PLIC);

    // Read data shows up one cycle after the request
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            region_q <= REGION_NONE;
        end else begin
            region_q <= bus_en_i ? region : REGION_NONE;
        end
    end

    always_comb begin
        case (region_q)
            REGION_DMEM: bus_rdata_o = dmem_rdata_i;
            REGION_RTC:  bus_rdata_o = rtc_rdata_i;
            REGION_PLIC: bus_rdata_o = plic_rdata_i;
            default:     bus_rdata_o = '0;   // unmapped reads as zero
        endcase
    end

endmodule

//--- source/pe_defs.svh
`ifndef PE_DEFS_SVH
`define PE_DEFS_SVH

////////////////////
// Bus widths
////////////////////

`define PE_ADDR_W      32
`define PE_DATA_W      32
`define PE_STRB_W      4
`define PE_MEM_ADDR_W  24

////////////////////
// Memory map
////////////////////

// Upper address byte of each region
`define PE_REGION_IMEM 8'h00
`define PE_REGION_DMEM 8'h01
`define PE_REGION_RTC  8'h02
`define PE_REGION_PLIC 8'h04

// RTC word offsets
`define RTC_OFF_MTIME_LO 4'h0
`define RTC_OFF_MTIME_HI 4'h4
`define RTC_OFF_CMP_LO   4'h8
`define RTC_OFF_CMP_HI   4'hC

// PLIC word offsets
`define PLIC_OFF_ENABLE  4'h0
`define PLIC_OFF_PENDING 4'h4
`define PLIC_OFF_CLAIM   4'h8

`define RTC_CMP_RESET 64'hFFFF_FFFF_FFFF_FFFF

`endif

//--- source/pe_dma_mux.sv
`timescale 1ns/1ps

`include "pe_defs.svh"

module pe_dma_mux (
    input  logic [`PE_ADDR_W-1:0] dma_addr_i,
    input  logic [`PE_DATA_W-1:0] idma_rdata_i,
    input  logic [`PE_DATA_W-1:0] ddma_rdata_i,
    output logic                  idma_en_o,
    output logic                  ddma_en_o,
    output logic [`PE_DATA_W-1:0] dma_rdata_o
);

    // Instruction window at 0x00, data window at 0x01
    assign idma_en_o = (dma_addr_i[`PE_ADDR_W-1 -: 8] == `PE_REGION_IMEM);
    assign ddma_en_o = (dma_addr_i[`PE_ADDR_W-1 -: 8] == `PE_REGION_DMEM);

    // Both windows share the upper seven bits, bit 24 picks the memory
    always_comb begin
        if (dma_addr_i[`PE_ADDR_W-1:25] == '0) begin
            dma_rdata_o = dma_addr_i[24] ? ddma_rdata_i : idma_rdata_i;
        end else begin
            dma_rdata_o = '0;
        end
    end

endmodule

//--- source/pe_periph_top.sv
`timescale 1ns/1ps

`include "pe_defs.svh"

module pe_periph_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    // Request bus
    input  logic                      bus_en_i,
    input  logic [`PE_STRB_W-1:0]     bus_we_i,
    input  logic [`PE_ADDR_W-1:0]     bus_addr_i,
    input  logic [`PE_DATA_W-1:0]     bus_wdata_i,
    output logic [`PE_DATA_W-1:0]     bus_rdata_o,

    // Data memory
    output logic                      dmem_en_o,
    output logic [`PE_STRB_W-1:0]     dmem_we_o,
    output logic [`PE_MEM_ADDR_W-1:0] dmem_addr_o,
    output logic [`PE_DATA_W-1:0]     dmem_wdata_o,
    input  logic [`PE_DATA_W-1:0]     dmem_rdata_i,

    // DMA port
    input  logic [`PE_STRB_W-1:0]     dma_we_i,
    input  logic [`PE_ADDR_W-1:0]     dma_addr_i,
    input  logic [`PE_DATA_W-1:0]     dma_wdata_i,
    output logic [`PE_DATA_W-1:0]     dma_rdata_o,

    output logic                      idma_en_o,
    output logic                      ddma_en_o,
    output logic [`PE_STRB_W-1:0]     dma_mem_we_o,
    output logic [`PE_MEM_ADDR_W-1:0] dma_mem_addr_o,
    output logic [`PE_DATA_W-1:0]     dma_mem_wdata_o,
    input  logic [`PE_DATA_W-1:0]     idma_rdata_i,
    input  logic [`PE_DATA_W-1:0]     ddma_rdata_i,

    // Interrupts and time
    input  logic                      ext_irq_i,
    output logic                      mti_o,
    output logic                      mei_o,
    output logic [63:0]               mtime_o
);

    logic                  rtc_en;
    logic                  plic_en;
    logic [`PE_DATA_W-1:0] rtc_rdata;
    logic [`PE_DATA_W-1:0] plic_rdata;

    ////////////////////
    // Memory side
    ////////////////////

    assign dmem_we_o       = bus_we_i;
    assign dmem_addr_o     = bus_addr_i[`PE_MEM_ADDR_W-1:0];
    assign dmem_wdata_o    = bus_wdata_i;

    assign dma_mem_we_o    = dma_we_i;
    assign dma_mem_addr_o  = dma_addr_i[`PE_MEM_ADDR_W-1:0];
    assign dma_mem_wdata_o = dma_wdata_i;

    pe_bus_decoder u_decoder (
        .clk_i        (clk_i       ),
        .rst_ni       (rst_ni      ),
        .bus_en_i     (bus_en_i    ),
        .bus_addr_i   (bus_addr_i  ),
        .dmem_en_o    (dmem_en_o   ),
        .rtc_en_o     (rtc_en      ),
        .plic_en_o    (plic_en     ),
        .rtc_rdata_i  (rtc_rdata   ),
        .plic_rdata_i (plic_rdata  ),
        .dmem_rdata_i (dmem_rdata_i),
        .bus_rdata_o  (bus_rdata_o )
    );

    ////////////////////
    // Peripherals
    ////////////////////

    pe_rtc u_rtc (
        .clk_i   (clk_i           ),
        .rst_ni  (rst_ni          ),
        .en_i    (rtc_en          ),
        .we_i    (bus_we_i        ),
        .addr_i  (bus_addr_i[3:0] ),
        .wdata_i (bus_wdata_i     ),
        .rdata_o (rtc_rdata       ),
        .mti_o   (mti_o           ),
        .mtime_o (mtime_o         )
    );

    pe_plic u_plic (
        .clk_i   (clk_i           ),
        .rst_ni  (rst_ni          ),
        .en_i    (plic_en         ),
        .we_i    (bus_we_i        ),
        .addr_i  (bus_addr_i[3:0] ),
        .wdata_i (bus_wdata_i     ),
        .rdata_o (plic_rdata      ),
        .irq_i   (ext_irq_i       ),
        .irq_o   (mei_o           )
    );

    pe_dma_mux u_dma_mux (
        .dma_addr_i   (dma_addr_i  ),
        .idma_rdata_i (idma_rdata_i),
        .ddma_rdata_i (ddma_rdata_i),
        .idma_en_o    (idma_en_o   ),
        .ddma_en_o    (ddma_en_o   ),
        .dma_rdata_o  (dma_rdata_o )
    );

endmodule

//--- source/pe_pkg.sv
package pe_pkg;

    // Region hit by a request on the memory-mapped bus
    typedef enum logic [1:0] {
        REGION_DMEM,
        REGION_RTC,
        REGION_PLIC,
        REGION_NONE
    } region_e;

    // RTC register select
    typedef enum logic [1:0] {
        RTC_REG_MTIME_LO,
        RTC_REG_MTIME_HI,
        RTC_REG_CMP_LO,
        RTC_REG_CMP_HI
    } rtc_reg_e;

    // PLIC register select, NONE for holes in the map
    typedef enum logic [1:0] {
        PLIC_REG_ENABLE,
        PLIC_REG_PENDING,
        PLIC_REG_CLAIM,
        PLIC_REG_NONE
    } plic_reg_e;

endpackage

//--- source/pe_plic.sv
`timescale 1ns/1ps

`include "pe_defs.svh"

module pe_plic
    import pe_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  en_i,
    input  logic [`PE_STRB_W-1:0] we_i,
    input  logic [3:0]            addr_i,
    input  logic [`PE_DATA_W-1:0] wdata_i,
    output logic [`PE_DATA_W-1:0] rdata_o,

    input  logic                  irq_i,
    output logic                  irq_o
);

    // Only one source, so its ID is fixed
    localparam logic [`PE_DATA_W-1:0] SRC_ID = 32'd1;

    plic_reg_e             reg_sel;
    logic                  rd_en;
    logic                  claim;
    logic                  enable_q;
    logic                  pending_q;
    logic [`PE_DATA_W-1:0] rd_val;

    always_comb begin
        case ({addr_i[3:2], 2'b00})
            `PLIC_OFF_ENABLE:  reg_sel = PLIC_REG_ENABLE;
            `PLIC_OFF_PENDING: reg_sel = PLIC_REG_PENDING;
            `PLIC_OFF_CLAIM:   reg_sel = PLIC_REG_CLAIM;
            default:           reg_sel = PLIC_REG_NONE;
        endcase
    end

    assign rd_en = en_i && !(|we_i);
    assign claim = rd_en && (reg_sel == PLIC_REG_CLAIM);

    // A new request wins over a claim at the same edge
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q  <= 1'b0;
            pending_q <= 1'b0;
        end else begin
            if (en_i && we_i[0] && reg_sel == PLIC_REG_ENABLE) begin
                enable_q <= wdata_i[0];
            end
            pending_q <= irq_i | (pending_q & ~claim);
        end
    end

    always_comb begin
        case (reg_sel)
            PLIC_REG_ENABLE:  rd_val = {{(`PE_DATA_W-1){1'b0}}, enable_q};
            PLIC_REG_PENDING: rd_val = {{(`PE_DATA_W-1){1'b0}}, pending_q};
            PLIC_REG_CLAIM:   rd_val = pending_q ? SRC_ID : '0;
            default:          rd_val = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            rdata_o <= rd_val;
        end
    end

    assign irq_o = pending_q & enable_q;

endmodule

//--- source/pe_rtc.sv
`timescale 1ns/1ps

`include "pe_defs.svh"

module pe_rtc
    import pe_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  en_i,
    input  logic [`PE_STRB_W-1:0] we_i,
    input  logic [3:0]            addr_i,
    input  logic [`PE_DATA_W-1:0] wdata_i,
    output logic [`PE_DATA_W-1:0] rdata_o,

    output logic                  mti_o,
    output logic [63:0]           mtime_o
);

    rtc_reg_e                reg_sel;
    logic                    wr_en;
    logic [63:0]             mtime_q;
    logic [63:0]             cmp_q;
    logic [`PE_DATA_W-1:0]   rd_val;

    // Byte-lane merge under the write strobes
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old_w;
        for (int i = 0; i < `PE_STRB_W; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    // Word decode, byte offset ignored
    always_comb begin
        case ({addr_i[3:2], 2'b00})
            `RTC_OFF_MTIME_LO: reg_sel = RTC_REG_MTIME_LO;
            `RTC_OFF_MTIME_HI: reg_sel = RTC_REG_MTIME_HI;
            `RTC_OFF_CMP_LO:   reg_sel = RTC_REG_CMP_LO;
            default:           reg_sel = RTC_REG_CMP_HI;
        endcase
    end

    assign wr_en = en_i && (|we_i);

    ////////////////////
    // Counter and compare
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= '0;
        end else if (wr_en && reg_sel == RTC_REG_MTIME_LO) begin
            mtime_q <= {mtime_q[63:32], merge_bytes(mtime_q[31:0], wdata_i, we_i)};
        end else if (wr_en && reg_sel == RTC_REG_MTIME_HI) begin
            mtime_q <= {merge_bytes(mtime_q[63:32], wdata_i, we_i), mtime_q[31:0]};
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // Compare starts at all ones so the timer stays quiet after reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cmp_q <= `RTC_CMP_RESET;
        end else if (wr_en && reg_sel == RTC_REG_CMP_LO) begin
            cmp_q <= {cmp_q[63:32], merge_bytes(cmp_q[31:0], wdata_i, we_i)};
        end else if (wr_en && reg_sel == RTC_REG_CMP_HI) begin
            cmp_q <= {merge_bytes(cmp_q[63:32], wdata_i, we_i), cmp_q[31:0]};
        end
    end

    ////////////////////
    // Register reads
    ////////////////////

    always_comb begin
        case (reg_sel)
            RTC_REG_MTIME_LO: rd_val = mtime_q[31:0];
            RTC_REG_MTIME_HI: rd_val = mtime_q[63:32];
            RTC_REG_CMP_LO:   rd_val = cmp_q[31:0];
            default:          rd_val = cmp_q[63:32];
        endcase
    end

    // Sampled at the request edge, so the pre-edge value is returned
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            rdata_o <= rd_val;
        end
    end

    assign mti_o   = (mtime_q >= cmp_q);
    assign mtime_o = mtime_q;

endmodule

//--- verification/pe_assertions.sv
`timescale 1ns/1ps

module pe_assertions (
    input logic clk_i,
    input logic rst_ni,
    input logic dmem_en_i,
    input logic rtc_en_i,
    input logic plic_en_i,
    input logic idma_en_i,
    input logic ddma_en_i,
    input logic mti_i,
    input logic mei_i
);

    a_one_region: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({dmem_en_i, rtc_en_i, plic_en_i}))
        else $error("more than one bus region enable is high");

    a_dma_window: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(idma_en_i && ddma_en_i))
        else $error("both DMA windows enabled");

    // First edge after reset release
    a_irq_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> !mti_i && !mei_i)
        else $error("interrupt high right after reset");

endmodule

bind pe_periph_top pe_assertions u_assertions (
    .clk_i      (clk_i     ),
    .rst_ni     (rst_ni    ),
    .dmem_en_i  (dmem_en_o ),
    .rtc_en_i   (rtc_en    ),
    .plic_en_i  (plic_en   ),
    .idma_en_i  (idma_en_o ),
    .ddma_en_i  (ddma_en_o ),
    .mti_i      (mti_o     ),
    .mei_i      (mei_o     )
);

//--- verification/pe_tb.sv
`timescale 1ns/1ps

`include "pe_defs.svh"

module pe_tb;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RST_CYCLES   = 16;
    localparam int          DIR_CYCLES   = 40;
    localparam int          RAND_CYCLES  = 800;
    localparam logic [31:0] IMEM_PATTERN = 32'h1A5E_0001;
    localparam logic [31:0] DMEM_PATTERN = 32'hD7A5_0002;

    logic                      clk_i;
    logic                      rst_ni;
    logic                      bus_en_i;
    logic [`PE_STRB_W-1:0]     bus_we_i;
    logic [`PE_ADDR_W-1:0]     bus_addr_i;
    logic [`PE_DATA_W-1:0]     bus_wdata_i;
    logic [`PE_DATA_W-1:0]     bus_rdata_o;
    logic                      dmem_en_o;
    logic [`PE_STRB_W-1:0]     dmem_we_o;
    logic [`PE_MEM_ADDR_W-1:0] dmem_addr_o;
    logic [`PE_DATA_W-1:0]     dmem_wdata_o;
    logic [`PE_DATA_W-1:0]     dmem_rdata_i;
    logic [`PE_STRB_W-1:0]     dma_we_i;
    logic [`PE_ADDR_W-1:0]     dma_addr_i;
    logic [`PE_DATA_W-1:0]     dma_wdata_i;
    logic [`PE_DATA_W-1:0]     dma_rdata_o;
    logic                      idma_en_o;
    logic                      ddma_en_o;
    logic [`PE_STRB_W-1:0]     dma_mem_we_o;
    logic [`PE_MEM_ADDR_W-1:0] dma_mem_addr_o;
    logic [`PE_DATA_W-1:0]     dma_mem_wdata_o;
    logic [`PE_DATA_W-1:0]     idma_rdata_i;
    logic [`PE_DATA_W-1:0]     ddma_rdata_i;
    logic                      ext_irq_i;
    logic                      mti_o;
    logic                      mei_o;
    logic [63:0]               mtime_o;

    // Reference model state
    logic [63:0] m_mtime;
    logic [63:0] m_cmp;
    logic        m_enable;
    logic        m_pending;
    logic [31:0] exp_mem [256];
    // External data memory contents
    logic [31:0] ext_mem [256];
    logic [7:0]  rd_idx;
    // Read expected one cycle after its request
    logic        pend_read;
    logic [31:0] pend_exp;
    logic [31:0] last_rd;

    pe_periph_top uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #((RST_CYCLES + DIR_CYCLES + RAND_CYCLES + 50) * CLK_PERIOD);
        $display("Watchdog timeout: the run took longer than its planned cycles");
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] apply_strobes(input logic [31:0] old_w,
                                                  input logic [31:0] new_w,
                                                  input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return {4{8'(idx)}} ^ 32'h5A3C_96F0;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1, "value check failed");
        end
    endtask

    ////////////////////
    // One bus cycle
    ////////////////////

    // Called on a falling edge, returns on the next one
    task automatic issue(input logic en, input logic [3:0] we, input logic [31:0] addr,
                         input logic [31:0] wdata);
        int               r;
        logic [7:0]       dma_top;
        logic [31:0]      dma_addr;
        logic [3:0]       dma_strb;
        logic [31:0]      dma_data;
        logic [31:0]      dma_exp;
        logic [7:0]       top;
        logic [1:0]       sel;
        logic [3:0][31:0] words;
        logic             mtime_wr;
        logic             claim;
        r = $urandom_range(0, 2);
        dma_top      = (r == 2) ? 8'($urandom()) : 8'(r);
        dma_addr     = {dma_top, 24'($urandom())};
        dma_strb     = 4'($urandom());
        dma_data     = $urandom();
        dmem_rdata_i = ext_mem[rd_idx];
        bus_en_i     = en;
        bus_we_i     = we;
        bus_addr_i   = addr;
        bus_wdata_i  = wdata;
        dma_addr_i   = dma_addr;
        dma_we_i     = dma_strb;
        dma_wdata_i  = dma_data;
        ext_irq_i    = ($urandom_range(0, 3) == 0);
        #1;
        // Results of the previous request
        last_rd = bus_rdata_o;
        if (pend_read) begin
            compare_value("bus_rdata_o", 64'(bus_rdata_o), 64'(pend_exp));
        end
        compare_value("mti_o", 64'(mti_o), 64'(m_mtime >= m_cmp));
        compare_value("mei_o", 64'(mei_o), 64'(m_pending & m_enable));
        compare_value("mtime_o", mtime_o, m_mtime);
        // Combinational outputs of this request
        top     = addr[31:24];
        dma_exp = (dma_top == `PE_REGION_IMEM) ? IMEM_PATTERN :
                  (dma_top == `PE_REGION_DMEM) ? DMEM_PATTERN : 32'h0;
        compare_value("dmem_en_o", 64'(dmem_en_o), 64'(en && top == `PE_REGION_DMEM));
        compare_value("dmem_we_o", 64'(dmem_we_o), 64'(we));
        compare_value("dmem_addr_o", 64'(dmem_addr_o), 64'(addr[23:0]));
        compare_value("dmem_wdata_o", 64'(dmem_wdata_o), 64'(wdata));
        compare_value("idma_en_o", 64'(idma_en_o), 64'(dma_top == `PE_REGION_IMEM));
        compare_value("ddma_en_o", 64'(ddma_en_o), 64'(dma_top == `PE_REGION_DMEM));
        compare_value("dma_rdata_o", 64'(dma_rdata_o), 64'(dma_exp));
        compare_value("dma_mem_we_o", 64'(dma_mem_we_o), 64'(dma_strb));
        compare_value("dma_mem_addr_o", 64'(dma_mem_addr_o), 64'(dma_addr[23:0]));
        compare_value("dma_mem_wdata_o", 64'(dma_mem_wdata_o), 64'(dma_data));
        // External memory acts on what the DUT forwards
        if (dmem_en_o && dmem_we_o != 4'h0) begin
            ext_mem[dmem_addr_o[9:2]] = apply_strobes(ext_mem[dmem_addr_o[9:2]],
                                                      dmem_wdata_o, dmem_we_o);
        end else if (dmem_en_o) begin
            rd_idx = dmem_addr_o[9:2];
        end
        // Model state for the coming rising edge
        pend_read = en && (we == 4'h0);
        pend_exp  = '0;
        sel       = addr[3:2];
        mtime_wr  = 1'b0;
        claim     = 1'b0;
        if (en && top == `PE_REGION_DMEM) begin
            pend_exp = exp_mem[addr[9:2]];
            if (we != 4'h0) begin
                exp_mem[addr[9:2]] = apply_strobes(exp_mem[addr[9:2]], wdata, we);
            end
        end
        words = {m_cmp, m_mtime};
        if (en && top == `PE_REGION_RTC) begin
            pend_exp = words[sel];
            if (we != 4'h0) begin
                words[sel] = apply_strobes(words[sel], wdata, we);
                mtime_wr   = !sel[1];
            end
        end
        m_cmp   = {words[3], words[2]};
        m_mtime = mtime_wr ? {words[1], words[0]} : m_mtime + 64'd1;
        if (en && top == `PE_REGION_PLIC) begin
            case (sel)
                2'd0:    pend_exp = {31'd0, m_enable};
                2'd1:    pend_exp = {31'd0, m_pending};
                2'd2:    pend_exp = {31'd0, m_pending};   // source ID 1 when pending
                default: pend_exp = '0;
            endcase
            if (we[0] && sel == 2'd0) begin
                m_enable = wdata[0];
            end
            claim = (we == 4'h0) && (sel == 2'd2);
        end
        m_pending = ext_irq_i | (m_pending & ~claim);
        @(negedge clk_i);
    endtask

    task automatic random_request();
        int          kind;
        logic [3:0]  strb;
        logic [7:0]  top;
        logic [31:0] addr;
        logic [31:0] data;
        kind = $urandom_range(0, 6);
        strb = ($urandom_range(0, 1) == 1) ? 4'($urandom_range(1, 15)) : 4'h0;
        data = $urandom();
        top  = 8'($urandom());
        if (top == `PE_REGION_DMEM || top == `PE_REGION_RTC || top == `PE_REGION_PLIC) begin
            top = 8'h10;
        end
        case (kind)
            0, 1: issue(1'b1, strb, {`PE_REGION_DMEM, 14'd0, 8'($urandom()), 2'b00}, data);
            2: begin
                // Values near the counter keep the timer compare interesting
                addr = {`PE_REGION_RTC, 20'd0, 2'($urandom()), 2'b00};
                data = addr[2] ? 32'h0 : m_mtime[31:0] + 32'($urandom_range(0, 60)) - 32'd30;
                issue(1'b1, strb, addr, data);
            end
            3: issue(1'b1, strb, {`PE_REGION_PLIC, 20'd0, 2'($urandom()), 2'b00}, data);
            4: issue(1'b1, 4'h0, {top, 24'($urandom())}, data);
            default: issue(1'b0, strb, {top, 24'($urandom())}, data);
        endcase
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        logic [31:0] t0;
        int          k;
        void'($urandom(51));
        rst_ni       = 1'b0;
        bus_en_i     = 1'b0;
        bus_we_i     = '0;
        bus_addr_i   = '0;
        bus_wdata_i  = '0;
        dmem_rdata_i = '0;
        dma_we_i     = '0;
        dma_addr_i   = 32'hFF00_0000;
        dma_wdata_i  = '0;
        idma_rdata_i = IMEM_PATTERN;
        ddma_rdata_i = DMEM_PATTERN;
        ext_irq_i    = 1'b0;
        for (int i = 0; i < 256; i++) begin
            exp_mem[i] = fill_word(i);
            ext_mem[i] = fill_word(i);
        end
        m_mtime   = '0;
        m_cmp     = `RTC_CMP_RESET;
        m_enable  = 1'b0;
        m_pending = 1'b0;
        rd_idx    = '0;
        pend_read = 1'b0;
        pend_exp  = '0;
        last_rd   = '0;

        repeat (RST_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;
        #1;
        compare_value("mti_o", 64'(mti_o), 64'd0);
        compare_value("mei_o", 64'(mei_o), 64'd0);
        compare_value("dmem_en_o", 64'(dmem_en_o), 64'd0);
        compare_value("idma_en_o", 64'(idma_en_o), 64'd0);
        compare_value("ddma_en_o", 64'(ddma_en_o), 64'd0);
        @(negedge clk_i);
        // Counter took the idle edge after release
        m_mtime = 64'd1;

        // Two mtime reads k cycles apart
        k = $urandom_range(2, 20);
        issue(1'b1, 4'h0, {`PE_REGION_RTC, 24'h0}, 32'h0);
        issue(1'b0, 4'h0, 32'h0, 32'h0);
        t0 = last_rd;
        repeat (k - 2) issue(1'b0, 4'h0, 32'h0, 32'h0);
        issue(1'b1, 4'h0, {`PE_REGION_RTC, 24'h0}, 32'h0);
        issue(1'b0, 4'h0, 32'h0, 32'h0);
        compare_value("mtime delta", 64'(last_rd - t0), 64'(k));

        // mtime write and read back, both halves
        issue(1'b1, 4'hF, {`PE_REGION_RTC, 24'h0}, 32'h0000_1000);
        issue(1'b1, 4'h0, {`PE_REGION_RTC, 24'h0}, 32'h0);
        issue(1'b1, 4'hF, {`PE_REGION_RTC, 24'h4}, 32'h0000_0002);
        issue(1'b1, 4'h0, {`PE_REGION_RTC, 24'h4}, 32'h0);
        issue(1'b1, 4'hF, {`PE_REGION_RTC, 24'h4}, 32'h0);
        issue(1'b1, 4'h1, {`PE_REGION_PLIC, 24'h0}, 32'h1);

        repeat (RAND_CYCLES) random_request();
        issue(1'b0, 4'h0, 32'h0, 32'h0);

        $display("Regression passed");
        $finish;
    end

endmodule
